/* source/ex_pkg.sv */
package ex_pkg;

  ////////////////////////////////////////
  // Widths and basic types
  ////////////////////////////////////////

  // Data path width
  localparam int unsigned xlen = 32;

  typedef logic [xlen-1:0] word_t;

  // Holds 0 to 32, so one bit wider than a 5-bit shift amount
  typedef logic [5:0] shamt_t;

  typedef logic [4:0] reg_addr_t;

  ////////////////////////////////////////
  // Operation encodings
  ////////////////////////////////////////

  // Functional unit select
  typedef enum logic {
    unit_alu = 1'b0,
    unit_div = 1'b1
  } ex_unit_e;

  typedef enum logic [3:0] {
    op_add  = 4'h0,
    op_sub  = 4'h1,
    op_and  = 4'h2,
    op_or   = 4'h3,
    op_xor  = 4'h4,
    op_sll  = 4'h5,
    op_srl  = 4'h6,
    op_sra  = 4'h7,
    op_slt  = 4'h8,
    op_sltu = 4'h9,
    op_beq  = 4'ha,
    op_bne  = 4'hb,
    op_blt  = 4'hc,
    op_bge  = 4'hd,
    op_bltu = 4'he,
    op_bgeu = 4'hf
  } alu_op_e;

  typedef enum logic [1:0] {
    op_div  = 2'd0,
    op_divu = 2'd1,
    op_rem  = 2'd2,
    op_remu = 2'd3
  } div_op_e;

  // Upper bits are not decoded by the divider
  typedef struct packed {
    logic [1:0] rsvd;
    div_op_e    op;
  } div_op_s;

  // Same 4-bit word, read by unit select
  typedef union packed {
    alu_op_e alu;
    div_op_s div;
  } ex_op_u;

  typedef enum logic [1:0] {
    shift_left        = 2'd0,
    shift_right_logic = 2'd1,
    shift_right_arith = 2'd2
  } shift_dir_e;

  ////////////////////////////////////////
  // Divider constants
  ////////////////////////////////////////

  // Worst case from acceptance to output valid
  localparam int unsigned div_max_cycles = 38;

  // Divider FSM states
  localparam logic [2:0] div_st_idle  = 3'd0;
  localparam logic [2:0] div_st_clz_b = 3'd1;
  localparam logic [2:0] div_st_clz_a = 3'd2;
  localparam logic [2:0] div_st_shift = 3'd3;
  localparam logic [2:0] div_st_step  = 3'd4;
  localparam logic [2:0] div_st_done  = 3'd5;

endpackage

/* source/shift_clz_if.sv */
`timescale 1ns/1ps

interface shift_clz_if;

  // Request side
  logic               req;
  ex_pkg::word_t      shift_data;
  ex_pkg::shamt_t     shift_amt;
  ex_pkg::shift_dir_e shift_dir;
  ex_pkg::word_t      clz_data;

  // Server side, combinational in the granted cycle
  logic               gnt;
  ex_pkg::word_t      shift_result;
  ex_pkg::shamt_t     clz_result;

  modport requester (
    output req, shift_data, shift_amt, shift_dir, clz_data,
    input  gnt, shift_result, clz_result
  );

  modport server (
    input  req, shift_data, shift_amt, shift_dir, clz_data,
    output gnt, shift_result, clz_result
  );

endinterface

/* source/shift_clz_unit.sv */
`timescale 1ns/1ps

module shift_clz_unit (
  shift_clz_if.server div_port,
  shift_clz_if.server alu_port
);

  // Selected requester
  logic               div_sel;
  ex_pkg::word_t      sel_data;
  ex_pkg::shamt_t     sel_amt;
  ex_pkg::shift_dir_e sel_dir;
  ex_pkg::word_t      sel_clz_data;

  // Shared results
  ex_pkg::word_t      shift_res;
  ex_pkg::shamt_t     clz_res;

  ////////////////////////////////////////
  // Fixed priority arbiter
  ////////////////////////////////////////

  // Divider always wins
  assign div_sel      = div_port.req;
  assign div_port.gnt = div_port.req;
  assign alu_port.gnt = alu_port.req & ~div_port.req;

  // Operand mux
  assign sel_data     = div_sel ? div_port.shift_data : alu_port.shift_data;
  assign sel_amt      = div_sel ? div_port.shift_amt  : alu_port.shift_amt;
  assign sel_dir      = div_sel ? div_port.shift_dir  : alu_port.shift_dir;
  assign sel_clz_data = div_sel ? div_port.clz_data   : alu_port.clz_data;

  ////////////////////////////////////////
  // Barrel shifter
  ////////////////////////////////////////

  always_comb begin
    case (sel_dir)
      ex_pkg::shift_left:        shift_res = sel_data << sel_amt;
      ex_pkg::shift_right_logic: shift_res = sel_data >> sel_amt;
      // Sign fill on arithmetic right shift
      ex_pkg::shift_right_arith: shift_res = ex_pkg::word_t'($signed(sel_data) >>> sel_amt);
      default:                   shift_res = sel_data;
    endcase
  end

  ////////////////////////////////////////
  // Count leading zeros
  ////////////////////////////////////////

  // Highest set bit wins, zero input gives 32
  always_comb begin
    clz_res = ex_pkg::shamt_t'(ex_pkg::xlen);
    for (int i = 0; i < ex_pkg::xlen; i++) begin
      if (sel_clz_data[i]) begin
        clz_res = ex_pkg::shamt_t'(ex_pkg::xlen - 1 - i);
      end
    end
  end

  // Results only reach the granted port
  assign div_port.shift_result = div_port.gnt ? shift_res : '0;
  assign div_port.clz_result   = div_port.gnt ? clz_res   : '0;
  assign alu_port.shift_result = alu_port.gnt ? shift_res : '0;
  assign alu_port.clz_result   = alu_port.gnt ? clz_res   : '0;

endmodule

/* source/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::alu_op_e     op_i,
  input  ex_pkg::word_t       operand_a_i,
  input  ex_pkg::word_t       operand_b_i,
  output ex_pkg::word_t       result_o,
  output logic                branch_taken_o,
  shift_clz_if.requester      shift_port
);

  logic          is_shift;
  logic          eq;
  logic          lt_s;
  logic          lt_u;
  ex_pkg::word_t shift_res;

  // Compare flags shared by slt and branches
  assign eq   = (operand_a_i == operand_b_i);
  assign lt_s = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_u = (operand_a_i < operand_b_i);

  ////////////////////////////////////////
  // Shared shifter request
  ////////////////////////////////////////

  assign is_shift = (op_i == ex_pkg::op_sll) |
                    (op_i == ex_pkg::op_srl) |
                    (op_i == ex_pkg::op_sra);

  always_comb begin
    shift_port.req        = is_shift;
    shift_port.shift_data = operand_a_i;
    // Only the low five bits of rs2 count
    shift_port.shift_amt  = {1'b0, operand_b_i[4:0]};
    shift_port.clz_data   = '0;
    case (op_i)
      ex_pkg::op_srl: shift_port.shift_dir = ex_pkg::shift_right_logic;
      ex_pkg::op_sra: shift_port.shift_dir = ex_pkg::shift_right_arith;
      default:        shift_port.shift_dir = ex_pkg::shift_left;
    endcase
  end

  // Zero if the divider holds the shifter
  assign shift_res = shift_port.gnt ? shift_port.shift_result : '0;

  ////////////////////////////////////////
  // Result and branch decision
  ////////////////////////////////////////

  always_comb begin
    result_o       = '0;
    branch_taken_o = 1'b0;
    case (op_i)
      ex_pkg::op_add:  result_o = operand_a_i + operand_b_i;
      ex_pkg::op_sub:  result_o = operand_a_i - operand_b_i;
      ex_pkg::op_and:  result_o = operand_a_i & operand_b_i;
      ex_pkg::op_or:   result_o = operand_a_i | operand_b_i;
      ex_pkg::op_xor:  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::op_sll,
      ex_pkg::op_srl,
      ex_pkg::op_sra:  result_o = shift_res;
      ex_pkg::op_slt:  result_o = {{(ex_pkg::xlen-1){1'b0}}, lt_s};
      ex_pkg::op_sltu: result_o = {{(ex_pkg::xlen-1){1'b0}}, lt_u};
      // Branches leave the result word at zero
      ex_pkg::op_beq:  branch_taken_o = eq;
      ex_pkg::op_bne:  branch_taken_o = ~eq;
      ex_pkg::op_blt:  branch_taken_o = lt_s;
      ex_pkg::op_bge:  branch_taken_o = ~lt_s;
      ex_pkg::op_bltu: branch_taken_o = lt_u;
      ex_pkg::op_bgeu: branch_taken_o = ~lt_u;
      default: begin
        result_o       = '0;
        branch_taken_o = 1'b0;
      end
    endcase
  end

endmodule

/* source/ex_div.sv */
`timescale 1ns/1ps

module ex_div (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  ex_pkg::div_op_e op_i,
  input  ex_pkg::word_t   dividend_i,
  input  ex_pkg::word_t   divisor_i,
  output logic            busy_o,
  output logic            done_o,
  output ex_pkg::word_t   result_o,
  shift_clz_if.requester  shift_port
);

  // FSM
  logic [2:0]      state_q;
  logic [2:0]      state_d;

  // Operation context
  ex_pkg::div_op_e op_q;
  logic            neg_quot_q;
  logic            neg_rem_q;

  // Datapath registers
  ex_pkg::word_t   rem_q;      // running remainder, starts as |dividend|
  ex_pkg::word_t   dvs_q;      // divisor, aligned after the shift state
  ex_pkg::word_t   quot_q;
  ex_pkg::shamt_t  clz_b_q;
  logic [4:0]      cnt_q;      // quotient bits left minus one

  // Input decode
  logic            is_signed;
  logic            a_neg;
  logic            b_neg;
  logic            div_zero;
  logic            overflow;
  ex_pkg::word_t   a_abs;
  ex_pkg::word_t   b_abs;

  // Step and output helpers
  ex_pkg::shamt_t  align_amt;
  logic            quot_zero;
  logic            rem_ge;
  ex_pkg::word_t   quot_fix;
  ex_pkg::word_t   rem_fix;

  ////////////////////////////////////////
  // Operand decode
  ////////////////////////////////////////

  assign is_signed = (op_i == ex_pkg::op_div) | (op_i == ex_pkg::op_rem);
  assign a_neg     = is_signed & dividend_i[ex_pkg::xlen-1];
  assign b_neg     = is_signed & divisor_i[ex_pkg::xlen-1];
  assign a_abs     = a_neg ? -dividend_i : dividend_i;
  assign b_abs     = b_neg ? -divisor_i  : divisor_i;

  // Special cases finish right after start
  assign div_zero  = (divisor_i == '0);
  assign overflow  = is_signed & (dividend_i == {1'b1, {(ex_pkg::xlen-1){1'b0}}}) &
                     (divisor_i == '1);

  // Divisor with fewer leading zeros is larger than the dividend
  assign align_amt = clz_b_q - shift_port.clz_result;
  assign quot_zero = (clz_b_q < shift_port.clz_result);

  assign rem_ge    = (rem_q >= dvs_q);

  ////////////////////////////////////////
  // Shared CLZ and shifter requests
  ////////////////////////////////////////

  always_comb begin
    shift_port.req        = 1'b0;
    shift_port.clz_data   = rem_q;
    shift_port.shift_data = dvs_q;
    shift_port.shift_amt  = {1'b0, cnt_q};
    shift_port.shift_dir  = ex_pkg::shift_left;
    case (state_q)
      ex_pkg::div_st_clz_b: begin
        shift_port.req      = 1'b1;
        shift_port.clz_data = dvs_q;
      end
      ex_pkg::div_st_clz_a,
      ex_pkg::div_st_shift: shift_port.req = 1'b1;
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ex_pkg::div_st_idle: begin
        if (start_i) begin
          state_d = (div_zero | overflow) ? ex_pkg::div_st_done : ex_pkg::div_st_clz_b;
        end
      end
      ex_pkg::div_st_clz_b: begin
        if (shift_port.gnt) state_d = ex_pkg::div_st_clz_a;
      end
      ex_pkg::div_st_clz_a: begin
        if (shift_port.gnt) begin
          state_d = quot_zero ? ex_pkg::div_st_done : ex_pkg::div_st_shift;
        end
      end
      ex_pkg::div_st_shift: begin
        if (shift_port.gnt) state_d = ex_pkg::div_st_step;
      end
      // One quotient bit per cycle
      ex_pkg::div_st_step: begin
        if (cnt_q == '0) state_d = ex_pkg::div_st_done;
      end
      ex_pkg::div_st_done: state_d = ex_pkg::div_st_idle;
      default:             state_d = ex_pkg::div_st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::div_st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    case (state_q)
      ex_pkg::div_st_idle: begin
        if (start_i) begin
          op_q       <= op_i;
          neg_quot_q <= (a_neg ^ b_neg) & ~div_zero & ~overflow;
          neg_rem_q  <= a_neg & ~div_zero & ~overflow;
          dvs_q      <= b_abs;
          if (div_zero) begin
            // All ones quotient, remainder is the dividend
            quot_q <= '1;
            rem_q  <= dividend_i;
          end else if (overflow) begin
            quot_q <= dividend_i;
            rem_q  <= '0;
          end else begin
            quot_q <= '0;
            rem_q  <= a_abs;
          end
        end
      end
      ex_pkg::div_st_clz_b: begin
        if (shift_port.gnt) clz_b_q <= shift_port.clz_result;
      end
      ex_pkg::div_st_clz_a: begin
        if (shift_port.gnt) cnt_q <= align_amt[4:0];
      end
      ex_pkg::div_st_shift: begin
        if (shift_port.gnt) dvs_q <= shift_port.shift_result;
      end
      // Restoring subtract step
      ex_pkg::div_st_step: begin
        quot_q <= {quot_q[ex_pkg::xlen-2:0], rem_ge};
        if (rem_ge) rem_q <= rem_q - dvs_q;
        dvs_q  <= dvs_q >> 1;
        cnt_q  <= cnt_q - 1'b1;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // Sign fix and outputs
  ////////////////////////////////////////

  assign quot_fix = neg_quot_q ? -quot_q : quot_q;
  assign rem_fix  = neg_rem_q  ? -rem_q  : rem_q;
  assign result_o = ((op_q == ex_pkg::op_rem) | (op_q == ex_pkg::op_remu)) ? rem_fix : quot_fix;

  assign busy_o   = (state_q != ex_pkg::div_st_idle);
  assign done_o   = (state_q == ex_pkg::div_st_done);

endmodule

/* source/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
  input  logic                clk,
  input  logic                rst_n,

  // Input handshake
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  ex_pkg::ex_unit_e    unit_i,
  input  ex_pkg::ex_op_u      op_i,
  input  ex_pkg::word_t       operand_a_i,
  input  ex_pkg::word_t       operand_b_i,
  input  ex_pkg::reg_addr_t   rd_addr_i,
  input  logic                rf_we_i,

  // EX/WB output
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output ex_pkg::word_t       out_wdata_o,
  output ex_pkg::reg_addr_t   out_rd_addr_o,
  output logic                out_rf_we_o,
  output logic                out_branch_taken_o
);

  // Handshake
  logic              accept;
  logic              alu_load;
  logic              div_start;

  // Unit results
  ex_pkg::word_t     alu_result;
  logic              alu_branch_taken;
  ex_pkg::word_t     div_result;
  logic              div_busy;
  logic              div_done;

  // Destination of the divide in flight
  ex_pkg::reg_addr_t pend_rd_q;
  logic              pend_we_q;

  // Shared shifter and CLZ ports
  shift_clz_if alu_sc_if ();
  shift_clz_if div_sc_if ();

  ////////////////////////////////////////
  // Input handshake and steering
  ////////////////////////////////////////

  // Stall while dividing or while the output is blocked
  assign in_ready_o = ~div_busy & ~(out_valid_o & ~out_ready_i);
  assign accept     = in_valid_i & in_ready_o;
  assign alu_load   = accept & (unit_i == ex_pkg::unit_alu);
  assign div_start  = accept & (unit_i == ex_pkg::unit_div);

  ////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////

  ex_alu i_alu (
    .op_i           (op_i.alu),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .result_o       (alu_result),
    .branch_taken_o (alu_branch_taken),
    .shift_port     (alu_sc_if.requester)
  );

  ex_div i_div (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (div_start),
    .op_i       (op_i.div.op),
    .dividend_i (operand_a_i),
    .divisor_i  (operand_b_i),
    .busy_o     (div_busy),
    .done_o     (div_done),
    .result_o   (div_result),
    .shift_port (div_sc_if.requester)
  );

  // Divider has priority on the shared unit
  shift_clz_unit i_shift_clz (
    .div_port (div_sc_if.server),
    .alu_port (alu_sc_if.server)
  );

  ////////////////////////////////////////
  // Pending divide destination
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (div_start) begin
      pend_rd_q <= rd_addr_i;
      pend_we_q <= rf_we_i;
    end
  end

  ////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////

  // Output is always empty by the time div_done fires
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o <= 1'b0;
      out_rf_we_o <= 1'b0;
    end else if (alu_load) begin
      out_valid_o <= 1'b1;
      out_rf_we_o <= rf_we_i;
    end else if (div_done) begin
      out_valid_o <= 1'b1;
      out_rf_we_o <= pend_we_q;
    end else if (out_ready_i) begin
      // Transfer done, nothing new
      out_valid_o <= 1'b0;
      out_rf_we_o <= 1'b0;
    end
  end

  // Payload holds while stalled
  always_ff @(posedge clk) begin
    if (alu_load) begin
      out_wdata_o        <= alu_result;
      out_rd_addr_o      <= rd_addr_i;
      out_branch_taken_o <= alu_branch_taken;
    end else if (div_done) begin
      out_wdata_o        <= div_result;
      out_rd_addr_o      <= pend_rd_q;
      out_branch_taken_o <= 1'b0;
    end
  end

endmodule

/* verification/ex_stage_tb.sv */
`timescale 1ns/1ps

module ex_stage_tb;

  // Room for the cases file
  localparam int max_cases = 64;
  // Input drive skew after the rising edge
  localparam int drive_dly = 2;

  // DUT ports
  logic                clk;
  logic                rst_n;
  logic                in_valid_i;
  logic                in_ready_o;
  ex_pkg::ex_unit_e    unit_i;
  ex_pkg::ex_op_u      op_i;
  ex_pkg::word_t       operand_a_i;
  ex_pkg::word_t       operand_b_i;
  ex_pkg::reg_addr_t   rd_addr_i;
  logic                rf_we_i;
  logic                out_valid_o;
  logic                out_ready_i;
  ex_pkg::word_t       out_wdata_o;
  ex_pkg::reg_addr_t   out_rd_addr_o;
  logic                out_rf_we_o;
  logic                out_branch_taken_o;

  // Test table loaded from the cases file
  string               case_name  [max_cases];
  ex_pkg::ex_unit_e    case_unit  [max_cases];
  ex_pkg::ex_op_u      case_op    [max_cases];
  ex_pkg::word_t       case_a     [max_cases];
  ex_pkg::word_t       case_b     [max_cases];
  ex_pkg::reg_addr_t   case_rd    [max_cases];
  logic                case_we    [max_cases];
  ex_pkg::word_t       case_wdata [max_cases];
  logic                case_br    [max_cases];
  int                  num_cases;
  bit                  cases_loaded;

  // Accepted operations waiting for their output, in order
  int                  expect_q [$];
  int                  done_count;

  ex_stage i_dut (
    .clk                (clk),
    .rst_n              (rst_n),
    .in_valid_i         (in_valid_i),
    .in_ready_o         (in_ready_o),
    .unit_i             (unit_i),
    .op_i               (op_i),
    .operand_a_i        (operand_a_i),
    .operand_b_i        (operand_b_i),
    .rd_addr_i          (rd_addr_i),
    .rf_we_i            (rf_we_i),
    .out_valid_o        (out_valid_o),
    .out_ready_i        (out_ready_i),
    .out_wdata_o        (out_wdata_o),
    .out_rd_addr_o      (out_rd_addr_o),
    .out_rf_we_o        (out_rf_we_o),
    .out_branch_taken_o (out_branch_taken_o)
  );

  ////////////////////////////////////////
  // Error handling and compares
  ////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input ex_pkg::word_t exp,
                            input ex_pkg::word_t act);
    if (act !== exp)
      abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_reg_addr(input string name, input ex_pkg::reg_addr_t exp,
                                input ex_pkg::reg_addr_t act);
    if (act !== exp)
      abort_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
  endtask

  ////////////////////////////////////////
  // Cases file
  ////////////////////////////////////////

  // Mnemonic to operation word, read by unit in the DUT
  task automatic decode_op(input string mnem, output ex_pkg::ex_op_u op, output bit known);
    known = 1'b1;
    op    = '0;
    case (mnem)
      "add":   op.alu = ex_pkg::op_add;
      "sub":   op.alu = ex_pkg::op_sub;
      "and":   op.alu = ex_pkg::op_and;
      "or":    op.alu = ex_pkg::op_or;
      "xor":   op.alu = ex_pkg::op_xor;
      "sll":   op.alu = ex_pkg::op_sll;
      "srl":   op.alu = ex_pkg::op_srl;
      "sra":   op.alu = ex_pkg::op_sra;
      "slt":   op.alu = ex_pkg::op_slt;
      "sltu":  op.alu = ex_pkg::op_sltu;
      "beq":   op.alu = ex_pkg::op_beq;
      "bne":   op.alu = ex_pkg::op_bne;
      "blt":   op.alu = ex_pkg::op_blt;
      "bge":   op.alu = ex_pkg::op_bge;
      "bltu":  op.alu = ex_pkg::op_bltu;
      "bgeu":  op.alu = ex_pkg::op_bgeu;
      "div":   op.div.op = ex_pkg::op_div;
      "divu":  op.div.op = ex_pkg::op_divu;
      "rem":   op.div.op = ex_pkg::op_rem;
      "remu":  op.div.op = ex_pkg::op_remu;
      default: known = 1'b0;
    endcase
  endtask

  task automatic load_cases();
    int             fd;
    int             n;
    int             rd_v;
    int             we_v;
    int             br_v;
    bit             known;
    string          line;
    string          name_s;
    string          unit_s;
    string          op_s;
    ex_pkg::word_t  a_v;
    ex_pkg::word_t  b_v;
    ex_pkg::word_t  w_v;
    ex_pkg::ex_op_u op_v;
    num_cases = 0;
    fd = $fopen("verification/ex_cases.txt", "r");
    if (fd == 0) abort_run("Could not open verification/ex_cases.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Skip blank and comment lines
      if (line.len() < 4 || line[0] == "#") continue;
      n = $sscanf(line, "%s %s %s %h %h %d %d %h %d",
                  name_s, unit_s, op_s, a_v, b_v, rd_v, we_v, w_v, br_v);
      if (n != 9) abort_run($sformatf("Malformed line in cases file: %s", line));
      if (num_cases == max_cases) abort_run("Cases file holds more tests than the table");
      decode_op(op_s, op_v, known);
      if (!known) abort_run($sformatf("Unknown operation %s in test %s", op_s, name_s));
      if (unit_s == "alu") begin
        case_unit[num_cases] = ex_pkg::unit_alu;
      end else if (unit_s == "div") begin
        case_unit[num_cases] = ex_pkg::unit_div;
      end else begin
        abort_run($sformatf("Unknown unit %s in test %s", unit_s, name_s));
      end
      case_name[num_cases]  = name_s;
      case_op[num_cases]    = op_v;
      case_a[num_cases]     = a_v;
      case_b[num_cases]     = b_v;
      case_rd[num_cases]    = ex_pkg::reg_addr_t'(rd_v);
      case_we[num_cases]    = (we_v != 0);
      case_wdata[num_cases] = w_v;
      case_br[num_cases]    = (br_v != 0);
      num_cases++;
    end
    $fclose(fd);
    if (num_cases == 0) abort_run("Cases file holds no tests");
  endtask

  ////////////////////////////////////////
  // Clock, back-pressure, watchdog
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Random out_ready_i, ready about three cycles in four
  initial begin
    out_ready_i = 1'b0;
    void'($urandom(32'h5537));
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      #drive_dly;
      out_ready_i = (($urandom % 4) != 0);
    end
  end

  // Worst case divide per test, doubled for back-pressure
  initial begin
    wait (cases_loaded);
    repeat (num_cases * (ex_pkg::div_max_cycles + 4) * 2) @(posedge clk);
    abort_run("Timeout: not all operations came out of the DUT in time");
  end

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  // Samples at the falling edge, between drive and capture
  initial begin : monitor
    ex_pkg::word_t     held_wdata;
    ex_pkg::reg_addr_t held_rd;
    logic              held_we;
    logic              held_br;
    logic              stalled;
    int                idx;
    stalled = 1'b0;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (out_valid_o === 1'b1) begin
        if (expect_q.size() == 0) begin
          abort_run("Output valid with no accepted operation outstanding");
        end else begin
          idx = expect_q[0];
          // Payload must hold through a stall
          if (stalled) begin
            check_word($sformatf("%s stall wdata", case_name[idx]), held_wdata, out_wdata_o);
            check_reg_addr($sformatf("%s stall rd", case_name[idx]), held_rd, out_rd_addr_o);
            check_flag($sformatf("%s stall rf_we", case_name[idx]), held_we, out_rf_we_o);
            check_flag($sformatf("%s stall taken", case_name[idx]), held_br,
                       out_branch_taken_o);
          end
          if (out_ready_i) begin
            void'(expect_q.pop_front());
            check_word(case_name[idx], case_wdata[idx], out_wdata_o);
            check_reg_addr(case_name[idx], case_rd[idx], out_rd_addr_o);
            check_flag($sformatf("%s rf_we", case_name[idx]), case_we[idx], out_rf_we_o);
            check_flag($sformatf("%s taken", case_name[idx]), case_br[idx],
                       out_branch_taken_o);
            done_count++;
            stalled = 1'b0;
          end else begin
            held_wdata = out_wdata_o;
            held_rd    = out_rd_addr_o;
            held_we    = out_rf_we_o;
            held_br    = out_branch_taken_o;
            stalled    = 1'b1;
          end
        end
      end else if (stalled) begin
        abort_run("out_valid_o dropped while the output was stalled");
      end
    end
  end

  ////////////////////////////////////////
  // Reset and input driver
  ////////////////////////////////////////

  initial begin
    bit accepted;
    rst_n        = 1'b0;
    in_valid_i   = 1'b0;
    unit_i       = ex_pkg::unit_alu;
    op_i         = '0;
    operand_a_i  = '0;
    operand_b_i  = '0;
    rd_addr_i    = '0;
    rf_we_i      = 1'b0;
    done_count   = 0;
    cases_loaded = 1'b0;
    load_cases();
    cases_loaded = 1'b1;
    repeat (2) @(posedge clk);
    #drive_dly;
    rst_n = 1'b1;
    // Output register empty before the first input
    @(negedge clk);
    check_flag("reset out_valid_o", 1'b0, out_valid_o);
    check_flag("reset out_rf_we_o", 1'b0, out_rf_we_o);
    @(posedge clk);
    #drive_dly;
    for (int i = 0; i < num_cases; i++) begin
      in_valid_i  = 1'b1;
      unit_i      = case_unit[i];
      op_i        = case_op[i];
      operand_a_i = case_a[i];
      operand_b_i = case_b[i];
      rd_addr_i   = case_rd[i];
      rf_we_i     = case_we[i];
      // Hold until the next edge takes it
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = (in_ready_o === 1'b1);
        if (accepted) expect_q.push_back(i);
        @(posedge clk);
        #drive_dly;
      end
    end
    in_valid_i = 1'b0;
    wait (done_count == num_cases);
    // Any stray output still reaches the monitor here
    repeat (3) @(negedge clk);
    // Stage drained, divider idle, ready for new input
    check_flag("idle in_ready_o", 1'b1, in_ready_o);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* verification/ex_cases.txt */
# name unit op rs1_hex rs2_hex rd_dec rf_we exp_wdata_hex exp_taken
# Operands and result are 32-bit hex, rf_we and exp_taken are 0 or 1
add_basic alu add 00000005 00000003 1 1 00000008 0
add_wrap alu add ffffffff 00000001 2 1 00000000 0
add_no_we alu add 00000010 00000020 0 0 00000030 0
sub_neg alu sub 00000003 00000005 3 1 fffffffe 0
and_mask alu and f0f0f0f0 0ff00ff0 4 1 00f000f0 0
or_mask alu or f0f0f0f0 0ff00ff0 5 1 fff0fff0 0
xor_mask alu xor f0f0f0f0 0ff00ff0 6 1 ff00ff00 0
sll_0 alu sll 12345678 00000000 7 1 12345678 0
sll_1 alu sll 80000001 00000001 8 1 00000002 0
sll_31 alu sll 00000001 0000001f 9 1 80000000 0
sll_amt_low5 alu sll 00000001 00000021 10 1 00000002 0
srl_1 alu srl 80000000 00000001 11 1 40000000 0
srl_31 alu srl 80000000 0000001f 12 1 00000001 0
sra_0 alu sra 87654321 00000000 13 1 87654321 0
sra_1 alu sra 80000000 00000001 14 1 c0000000 0
sra_31 alu sra 80000000 0000001f 15 1 ffffffff 0
slt_neg alu slt ffffffff 00000001 16 1 00000001 0
sltu_large alu sltu ffffffff 00000001 17 1 00000000 0
slt_equal alu slt 00000005 00000005 18 1 00000000 0
beq_equal alu beq 0000abcd 0000abcd 0 0 00000000 1
beq_differ alu beq 0000abcd 0000abce 0 0 00000000 0
bne_differ alu bne 00000001 00000002 0 0 00000000 1
blt_neg alu blt ffffffff 00000001 0 0 00000000 1
bge_neg alu bge ffffffff 00000001 0 0 00000000 0
bltu_large alu bltu ffffffff 00000001 0 0 00000000 0
bgeu_large alu bgeu ffffffff 00000001 0 0 00000000 1
div_pos div div 00000064 00000007 19 1 0000000e 0
div_neg div div ffffff9c 00000007 20 1 fffffff2 0
rem_neg div rem ffffff9c 00000007 21 1 fffffffe 0
rem_neg_divisor div rem 00000064 fffffff9 22 1 00000002 0
divu_large div divu ffffffff 00000010 23 1 0fffffff 0
remu_large div remu ffffffff 00000010 24 1 0000000f 0
div_by_zero div div 00001234 00000000 25 1 ffffffff 0
divu_by_zero div divu 00001234 00000000 26 1 ffffffff 0
rem_by_zero div rem 80001234 00000000 27 1 80001234 0
remu_by_zero div remu 00001234 00000000 28 1 00001234 0
div_overflow div div 80000000 ffffffff 29 1 80000000 0
rem_overflow div rem 80000000 ffffffff 30 1 00000000 0
divu_small div divu 00000003 00000007 31 1 00000000 0
rem_small_neg div rem fffffffd 00000007 1 1 fffffffd 0
add_after_div alu add 7fffffff 00000001 2 1 80000000 0

/* tb.f */
source/ex_pkg.sv
source/shift_clz_if.sv
source/shift_clz_unit.sv
source/ex_alu.sv
source/ex_div.sv
source/ex_stage.sv
verification/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  # RTL in compile order
  - source/ex_pkg.sv
  - source/shift_clz_if.sv
  - source/shift_clz_unit.sv
  - source/ex_alu.sv
  - source/ex_div.sv
  - source/ex_stage.sv

  # Testbench
  - target: test
    files:
      - verification/ex_stage_tb.sv
